//--- rtl/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int WORD_OFFSET_WIDTH = 2;                      // four words per line
    localparam int BYTE_OFFSET_WIDTH = WORD_OFFSET_WIDTH + 2;
    localparam int LINE_BITS         = 128;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic        way_t;

    // word 0 sits in the low bits
    typedef word_t [(1 << WORD_OFFSET_WIDTH)-1:0] line_t;

endpackage

`default_nettype wire

//--- rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // strobe patterns on the apb side, they also give the access size
    localparam logic [3:0] STRB_BYTE = 4'b0001;
    localparam logic [3:0] STRB_HALF = 4'b0011;
    localparam logic [3:0] STRB_WORD = 4'b1111;

    // memory side request kind
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_t;

endpackage

`default_nettype wire

//--- rtl/dcache_ifs.sv
`timescale 1ns/1ps
`default_nettype none

interface array_if import cache_geom_pkg::*; #(
    parameter int INDEX_WIDTH = 4
);
    localparam int TAG_WIDTH  = 32 - BYTE_OFFSET_WIDTH - INDEX_WIDTH;
    localparam int LINE_BYTES = LINE_BITS / 8;

    logic                       rd_en;
    logic [INDEX_WIDTH-1:0]     rd_index;
    logic [1:0][TAG_WIDTH:0]    rd_tag;       // {valid, tag} per way
    line_t [1:0]                rd_data;
    logic [1:0]                 rd_dirty;
    way_t                       victim_way;

    logic [INDEX_WIDTH-1:0]     wr_index;
    logic [1:0]                 tag_we;
    logic [TAG_WIDTH:0]         tag_wdata;
    logic [1:0][LINE_BYTES-1:0] data_we;      // byte mask per way
    line_t                      data_wdata;
    logic [1:0]                 dirty_we;
    logic                       dirty_wdata;
    logic                       lru_we;
    way_t                       lru_way;      // way just used

    modport master (
        output rd_en, rd_index, wr_index, tag_we, tag_wdata, data_we, data_wdata,
               dirty_we, dirty_wdata, lru_we, lru_way,
        input  rd_tag, rd_data, rd_dirty, victim_way
    );

    modport slave (
        input  rd_en, rd_index, wr_index, tag_we, tag_wdata, data_we, data_wdata,
               dirty_we, dirty_wdata, lru_we, lru_way,
        output rd_tag, rd_data, rd_dirty, victim_way
    );
endinterface

interface line_if import cache_geom_pkg::*, bus_pkg::*; ();
    logic    req;     // one cycle pulse
    mem_op_t op;
    addr_t   addr;
    line_t   wline;
    logic    busy;
    logic    done;    // one cycle pulse
    line_t   rline;

    modport master (output req, op, addr, wline, input busy, done, rline);
    modport slave (input req, op, addr, wline, output busy, done, rline);
endinterface

`default_nettype wire

//--- rtl/way_ram.sv
`timescale 1ns/1ps
`default_nettype none

module way_ram #(
    parameter type entry_t    = logic [31:0],
    parameter int  DEPTH_BITS = 4
) (
    input  wire logic                  clk,
    input  wire logic                  i_rd_en,
    input  wire logic [DEPTH_BITS-1:0] i_rd_addr,
    input  wire logic [DEPTH_BITS-1:0] i_wr_addr,
    input  wire logic                  i_we,
    input  wire entry_t                i_wdata,
    output entry_t                     o_rdata
);
    entry_t mem [1 << DEPTH_BITS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wr_addr] <= i_wdata;   // whole entry
        end
        if (i_rd_en) begin
            o_rdata <= mem[i_rd_addr];   // held until the next read
        end
    end

    // the controller must present a resolved index on every lookup
    a_rd_addr_known: assert property (
        @(posedge clk) i_rd_en |-> !$isunknown(i_rd_addr)
    );

endmodule

`default_nettype wire

//--- rtl/cache_arrays.sv
`timescale 1ns/1ps
`default_nettype none

module cache_arrays import cache_geom_pkg::*; #(
    parameter int INDEX_WIDTH = 4
) (
    input wire logic clk,
    input wire logic rstn,
    array_if.slave   arr
);
    localparam int TAG_WIDTH  = 32 - BYTE_OFFSET_WIDTH - INDEX_WIDTH;
    localparam int LINE_BYTES = LINE_BITS / 8;
    localparam int SETS       = 1 << INDEX_WIDTH;

    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    tag_entry_t tag_rd [2];
    line_t      line_rd [2];
    logic [1:0] valid_q [SETS];   // ram copy of valid is undefined until written
    logic [1:0] dirty_q [SETS];
    way_t       lru_q [SETS];     // least recently used way of each set
    logic [1:0] valid_rd_q;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [LINE_BYTES-1:0][7:0] old_bytes;
        logic [LINE_BYTES-1:0][7:0] new_bytes;
        logic [LINE_BYTES-1:0][7:0] merged;

        way_ram #(.entry_t(tag_entry_t), .DEPTH_BITS(INDEX_WIDTH)) u_tag_ram (
            .clk       (clk),
            .i_rd_en   (arr.rd_en),
            .i_rd_addr (arr.rd_index),
            .i_wr_addr (arr.wr_index),
            .i_we      (arr.tag_we[w]),
            .i_wdata   (arr.tag_wdata),
            .o_rdata   (tag_rd[w])
        );

        // unmasked bytes keep the line held at the ram output
        always_comb begin
            old_bytes = line_rd[w];
            new_bytes = arr.data_wdata;
            for (int b = 0; b < LINE_BYTES; b++) begin
                merged[b] = arr.data_we[w][b] ? new_bytes[b] : old_bytes[b];
            end
        end

        way_ram #(.entry_t(line_t), .DEPTH_BITS(INDEX_WIDTH)) u_data_ram (
            .clk       (clk),
            .i_rd_en   (arr.rd_en),
            .i_rd_addr (arr.rd_index),
            .i_wr_addr (arr.wr_index),
            .i_we      (|arr.data_we[w]),
            .i_wdata   (merged),
            .o_rdata   (line_rd[w])
        );
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            arr.rd_tag[w] = {tag_rd[w].valid & valid_rd_q[w], tag_rd[w].tag};
        end
    end
    assign arr.rd_data = {line_rd[1], line_rd[0]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
            valid_rd_q     <= '0;
            arr.rd_dirty   <= '0;
            arr.victim_way <= 1'b0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (arr.tag_we[w]) begin
                    valid_q[arr.wr_index][w] <= arr.tag_wdata[TAG_WIDTH];
                end
                if (arr.dirty_we[w]) begin
                    dirty_q[arr.wr_index][w] <= arr.dirty_wdata;
                end
            end
            if (arr.lru_we) begin
                lru_q[arr.wr_index] <= ~arr.lru_way;   // the other way becomes lru
            end
            if (arr.rd_en) begin   // same timing as the ram read
                valid_rd_q     <= valid_q[arr.rd_index];
                arr.rd_dirty   <= dirty_q[arr.rd_index];
                arr.victim_way <= lru_q[arr.rd_index];
            end
        end
    end

    // a fill or hit only ever names one way
    a_tag_we_single: assert property (@(posedge clk) disable iff (!rstn) !(&arr.tag_we));

endmodule

`default_nettype wire

//--- rtl/apb_cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module apb_cache_ctrl import cache_geom_pkg::*, bus_pkg::*; #(
    parameter int INDEX_WIDTH = 4
) (
    input  wire logic  clk,
    input  wire logic  rstn,
    input  wire logic  i_psel,
    input  wire logic  i_penable,
    input  wire logic  i_pwrite,
    input  wire addr_t i_paddr,
    input  wire word_t i_pwdata,
    input  wire strb_t i_pstrb,
    output word_t      o_prdata,
    output logic       o_pready,
    output logic       o_pslverr,
    array_if.master    arr,
    line_if.master     mem
);
    localparam int TAG_WIDTH  = 32 - BYTE_OFFSET_WIDTH - INDEX_WIDTH;
    localparam int LINE_BYTES = LINE_BITS / 8;

    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        S_IDLE, S_LOOKUP, S_WB, S_REFILL_REQ, S_REFILL_WAIT, S_FILL
    } state_t;

    state_t state_q, state_d;

    addr_t req_addr_q;
    word_t req_wdata_q;   // already moved to its byte lanes
    strb_t req_size_q;    // strobe as given, encodes the size
    strb_t req_lanes_q;
    logic  req_write_q;

    logic [INDEX_WIDTH-1:0]       req_index;
    logic [TAG_WIDTH-1:0]         req_tag;
    logic [WORD_OFFSET_WIDTH-1:0] req_word;
    logic                         start;
    logic                         misaligned;
    tag_entry_t                   entry [2];
    logic [1:0]                   hit;
    way_t                         hit_way;
    way_t                         vic;
    logic [LINE_BYTES-1:0]        line_mask;
    logic [LINE_BYTES-1:0][7:0]   refill_bytes;
    logic [LINE_BYTES-1:0][7:0]   wdata_bytes;
    logic [LINE_BYTES-1:0][7:0]   fill_bytes;
    line_t                        sel_line;
    word_t                        sel_word;

    assign req_index = req_addr_q[BYTE_OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_tag   = req_addr_q[31 -: TAG_WIDTH];
    assign req_word  = req_addr_q[2 +: WORD_OFFSET_WIDTH];
    assign start     = (state_q == S_IDLE) && i_psel && i_penable;   // first access cycle

    always_comb begin
        case (i_pstrb)
            STRB_HALF: misaligned = i_paddr[0];
            STRB_WORD: misaligned = |i_paddr[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start && !misaligned) begin
            req_addr_q  <= i_paddr;
            req_wdata_q <= i_pwdata << {i_paddr[1:0], 3'b000};
            req_lanes_q <= i_pstrb << i_paddr[1:0];
            req_size_q  <= i_pstrb;
            req_write_q <= i_pwrite;
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            entry[w] = arr.rd_tag[w];
            hit[w]   = entry[w].valid && (entry[w].tag == req_tag);
        end
    end
    assign hit_way   = hit[1];
    assign vic       = arr.victim_way;
    assign line_mask = LINE_BYTES'(req_lanes_q) << {req_word, 2'b00};

    // pending write goes over the returned line
    assign refill_bytes = mem.rline;
    assign wdata_bytes  = {(LINE_BYTES / 4){req_wdata_q}};
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            fill_bytes[b] = (req_write_q && line_mask[b]) ? wdata_bytes[b] : refill_bytes[b];
        end
    end

    assign sel_line = (state_q == S_FILL) ? line_t'(fill_bytes) : arr.rd_data[hit_way];
    assign sel_word = sel_line[req_word];

    always_comb begin   // sub-word reads come back zero extended
        case (req_size_q)
            STRB_BYTE: o_prdata = 32'(sel_word[{req_addr_q[1:0], 3'b000} +: 8]);
            STRB_HALF: o_prdata = 32'(sel_word[{req_addr_q[1], 4'b0000} +: 16]);
            default:   o_prdata = sel_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d         = state_q;
        o_pready        = 1'b0;
        o_pslverr       = 1'b0;
        arr.rd_en       = 1'b0;
        arr.rd_index    = i_paddr[BYTE_OFFSET_WIDTH +: INDEX_WIDTH];
        arr.wr_index    = req_index;
        arr.tag_we      = '0;
        arr.tag_wdata   = {1'b1, req_tag};
        arr.data_we     = '0;
        arr.data_wdata  = wdata_bytes;
        arr.dirty_we    = '0;
        arr.dirty_wdata = req_write_q;   // a read fill leaves the line clean
        arr.lru_we      = 1'b0;
        arr.lru_way     = hit_way;
        mem.req         = 1'b0;
        mem.op          = MEM_READ;
        mem.addr        = {req_tag, req_index, BYTE_OFFSET_WIDTH'(0)};
        mem.wline       = arr.rd_data[vic];
        case (state_q)
            S_IDLE: begin
                if (start && misaligned) begin
                    o_pready  = 1'b1;
                    o_pslverr = 1'b1;
                end else if (start) begin
                    arr.rd_en = 1'b1;
                    state_d   = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (|hit) begin
                    o_pready   = 1'b1;
                    arr.lru_we = 1'b1;
                    if (req_write_q) begin
                        arr.data_we[hit_way]  = line_mask;
                        arr.dirty_we[hit_way] = 1'b1;
                    end
                    state_d = S_IDLE;
                end else if (entry[vic].valid && arr.rd_dirty[vic]) begin
                    state_d = S_WB;
                end else begin
                    state_d = S_REFILL_REQ;
                end
            end
            S_WB: begin
                mem.req  = !mem.busy && !mem.done;   // one request, then wait
                mem.op   = MEM_WRITE;
                mem.addr = {entry[vic].tag, req_index, BYTE_OFFSET_WIDTH'(0)};
                if (mem.done) begin
                    state_d = S_REFILL_REQ;
                end
            end
            S_REFILL_REQ: begin
                mem.req = !mem.busy;
                if (!mem.busy) begin
                    state_d = S_REFILL_WAIT;
                end
            end
            S_REFILL_WAIT: begin
                if (mem.done) begin
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                o_pready          = 1'b1;
                arr.tag_we[vic]   = 1'b1;
                arr.data_we[vic]  = '1;
                arr.data_wdata    = fill_bytes;
                arr.dirty_we[vic] = 1'b1;
                arr.lru_we        = 1'b1;
                arr.lru_way       = vic;
                state_d           = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    // completion only ever lands inside an apb access phase
    a_pready_in_access: assert property (
        @(posedge clk) disable iff (!rstn) o_pready |-> (i_psel && i_penable)
    );

endmodule

`default_nettype wire

//--- rtl/line_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module line_mem_port import cache_geom_pkg::*, bus_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rstn,
    line_if.slave      mem,
    output logic       o_mem_valid,
    input  wire logic  i_mem_ready,
    output mem_op_t    o_mem_op,
    output addr_t      o_mem_addr,
    output line_t      o_mem_wdata,
    input  wire logic  i_mem_rvalid,
    input  wire line_t i_mem_rdata
);
    logic    valid_q;
    logic    busy_q;
    logic    rd_wait_q;   // read taken, line not back yet
    logic    done_q;
    mem_op_t op_q;
    addr_t   addr_q;
    line_t   wline_q;     // write-back buffer
    line_t   rline_q;     // refill buffer
    logic    take;
    logic    accept;
    logic    ret;

    assign take   = mem.req;
    assign accept = valid_q && i_mem_ready;
    assign ret    = rd_wait_q && i_mem_rvalid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q   <= 1'b0;
            busy_q    <= 1'b0;
            rd_wait_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (take) begin
                valid_q <= 1'b1;
                busy_q  <= 1'b1;
            end
            if (accept) begin
                valid_q <= 1'b0;
                if (op_q == MEM_WRITE) begin
                    done_q <= 1'b1;
                    busy_q <= 1'b0;
                end else begin
                    rd_wait_q <= 1'b1;
                end
            end
            if (ret) begin
                rd_wait_q <= 1'b0;
                done_q    <= 1'b1;
                busy_q    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q    <= mem.op;
            addr_q  <= mem.addr;
            wline_q <= mem.wline;
        end
        if (ret) begin
            rline_q <= i_mem_rdata;
        end
    end

    assign o_mem_valid = valid_q;
    assign o_mem_op    = op_q;
    assign o_mem_addr  = addr_q;
    assign o_mem_wdata = wline_q;
    assign mem.busy    = busy_q;
    assign mem.done    = done_q;
    assign mem.rline   = rline_q;

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        (o_mem_valid && !i_mem_ready) |=> (o_mem_valid && $stable(o_mem_op)
            && $stable(o_mem_addr) && $stable(o_mem_wdata))
    );

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top import cache_geom_pkg::*, bus_pkg::*; #(
    parameter int INDEX_WIDTH = 4   // 16 sets
) (
    input  wire logic  clk,
    input  wire logic  rstn,
    input  wire logic  i_psel,
    input  wire logic  i_penable,
    input  wire logic  i_pwrite,
    input  wire addr_t i_paddr,
    input  wire word_t i_pwdata,
    input  wire strb_t i_pstrb,
    output word_t      o_prdata,
    output logic       o_pready,
    output logic       o_pslverr,
    output logic       o_mem_valid,
    input  wire logic  i_mem_ready,
    output mem_op_t    o_mem_op,
    output addr_t      o_mem_addr,
    output line_t      o_mem_wdata,
    input  wire logic  i_mem_rvalid,
    input  wire line_t i_mem_rdata
);
    array_if #(.INDEX_WIDTH(INDEX_WIDTH)) u_array_if ();
    line_if u_line_if ();

    apb_cache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) u_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .i_pstrb   (i_pstrb),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .arr       (u_array_if.master),
        .mem       (u_line_if.master)
    );

    cache_arrays #(.INDEX_WIDTH(INDEX_WIDTH)) u_arrays (
        .clk  (clk),
        .rstn (rstn),
        .arr  (u_array_if.slave)
    );

    line_mem_port u_mem_port (
        .clk          (clk),
        .rstn         (rstn),
        .mem          (u_line_if.slave),
        .o_mem_valid  (o_mem_valid),
        .i_mem_ready  (i_mem_ready),
        .o_mem_op     (o_mem_op),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .i_mem_rvalid (i_mem_rvalid),
        .i_mem_rdata  (i_mem_rdata)
    );

endmodule

`default_nettype wire

//--- testbench/tb_line_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_line_memory import cache_geom_pkg::*, bus_pkg::*; #(
    parameter word_t PATTERN = 32'hC0DE_A500
) (
    input  wire logic    clk,
    input  wire logic    i_mem_valid,
    output logic         o_mem_ready,
    input  wire mem_op_t i_mem_op,
    input  wire addr_t   i_mem_addr,
    input  wire line_t   i_mem_wdata,
    output logic         o_mem_rvalid,
    output line_t        o_mem_rdata,
    output int           o_req_count,
    output int           o_wb_count,
    output addr_t        o_wb_addr,   // last write-back
    output line_t        o_wb_line
);
    line_t  lines [addr_t];   // only lines that were written back
    integer seed;

    function automatic line_t read_line(input addr_t line_addr);
        line_t l;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        for (int k = 0; k < (1 << WORD_OFFSET_WIDTH); k++) begin
            l[k] = (line_addr + addr_t'(4 * k)) ^ PATTERN;   // untouched memory
        end
        return l;
    endfunction

    initial begin
        int      gap;
        mem_op_t op;
        addr_t   addr;
        line_t   wline;
        seed         = 48114;
        o_mem_ready  = 1'b0;
        o_mem_rvalid = 1'b0;
        o_mem_rdata  = '0;
        o_req_count  = 0;
        o_wb_count   = 0;
        o_wb_addr    = '0;
        o_wb_line    = '0;
        forever begin
            @(negedge clk);
            if (i_mem_valid === 1'b1) begin
                gap = $unsigned($random(seed)) % 4;   // back-pressure
                repeat (gap + 1) @(posedge clk);
                #1;
                o_mem_ready = 1'b1;
                @(negedge clk);
                op    = i_mem_op;
                addr  = i_mem_addr;
                wline = i_mem_wdata;
                @(posedge clk);   // handshake edge
                #1;
                o_mem_ready = 1'b0;
                o_req_count++;
                if (op == MEM_WRITE) begin
                    lines[addr] = wline;
                    o_wb_addr   = addr;
                    o_wb_line   = wline;
                    o_wb_count++;
                    $display("%0t: write-back of line %h data %h", $time, addr, wline);
                end else begin
                    gap = $unsigned($random(seed)) % 4;   // read latency
                    repeat (gap) begin
                        @(posedge clk);
                        #1;
                    end
                    o_mem_rvalid = 1'b1;
                    o_mem_rdata  = read_line(addr);
                    @(posedge clk);
                    #1;
                    o_mem_rvalid = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import cache_geom_pkg::*, bus_pkg::*; ();
    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 16;
    localparam word_t FILL_PATTERN = 32'hC0DE_A500;
    localparam string TRACE_FILE   = "testbench/dcache_trace.txt";

    typedef struct packed {
        logic [7:0] op;
        addr_t      addr;
        word_t      wdata;
        strb_t      strb;
        word_t      exp_data;
        logic       exp_err;
    } trace_op_t;

    logic    clk;
    logic    rstn;
    logic    psel;
    logic    penable;
    logic    pwrite;
    addr_t   paddr;
    word_t   pwdata;
    strb_t   pstrb;
    word_t   prdata;
    logic    pready;
    logic    pslverr;
    logic    mem_valid;
    logic    mem_ready;
    mem_op_t mem_op;
    addr_t   mem_addr;
    line_t   mem_wdata;
    logic    mem_rvalid;
    line_t   mem_rdata;
    int      req_count;
    int      wb_count;
    addr_t   wb_addr;
    line_t   wb_line;

    trace_op_t ops [$];
    bit        trace_loaded = 1'b0;
    int        word_errors  = 0;
    int        line_errors  = 0;
    int        flag_errors  = 0;
    int        other_errors = 0;

    dcache_top #(.INDEX_WIDTH(4)) u_dcache_top (
        .clk(clk), .rstn(rstn),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
        .i_pwdata(pwdata), .i_pstrb(pstrb), .o_prdata(prdata), .o_pready(pready),
        .o_pslverr(pslverr), .o_mem_valid(mem_valid), .i_mem_ready(mem_ready),
        .o_mem_op(mem_op), .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata),
        .i_mem_rvalid(mem_rvalid), .i_mem_rdata(mem_rdata)
    );

    tb_line_memory #(.PATTERN(FILL_PATTERN)) u_line_memory (
        .clk(clk), .i_mem_valid(mem_valid), .o_mem_ready(mem_ready), .i_mem_op(mem_op),
        .i_mem_addr(mem_addr), .i_mem_wdata(mem_wdata), .o_mem_rvalid(mem_rvalid),
        .o_mem_rdata(mem_rdata), .o_req_count(req_count), .o_wb_count(wb_count),
        .o_wb_addr(wb_addr), .o_wb_line(wb_line)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory content before any write-back
    function automatic line_t pattern_line(input addr_t line_addr);
        line_t l;
        for (int k = 0; k < (1 << WORD_OFFSET_WIDTH); k++) begin
            l[k] = (line_addr + addr_t'(4 * k)) ^ FILL_PATTERN;
        end
        return l;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            line_errors++;
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
            flag_errors++;
        end
    endtask

    // one apb transfer, response sampled mid-cycle
    task automatic apb_transfer(input logic write, input addr_t addr, input word_t wdata,
                                input strb_t strb, output word_t rdata, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        pstrb   = strb;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (pready !== 1'b1) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = RESET_CYCLES + ops.size() * 200;
        repeat (limit) @(posedge clk);
        $display("timeout: the trace did not finish within %0d cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : main
        int          fd;
        int          n;
        int          reqs_before;
        int          wb_seen;
        string       text;
        logic [7:0]  f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_strb;
        logic [31:0] f_exp;
        logic [31:0] f_err;
        trace_op_t   t;
        word_t       rdata;
        logic        err;
        line_t       exp_line;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        rstn    = 1'b0;
        wb_seen = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                text = "";
                n = $fgets(text, fd);
                if (n > 0 && text.len() > 1 && text[0] != "#") begin
                    n = $sscanf(text, "%c %h %h %h %h %h",
                                f_op, f_addr, f_wdata, f_strb, f_exp, f_err);
                    if (n == 6) begin
                        t = '{f_op, f_addr, f_wdata, strb_t'(f_strb), f_exp, f_err[0]};
                        ops.push_back(t);
                    end
                end
            end
            $fclose(fd);
        end
        if (ops.size() == 0) begin
            $display("the trace holds no operations");
            other_errors++;
        end
        trace_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;

        foreach (ops[i]) begin
            t = ops[i];
            case (t.op)
                "R", "H", "M": begin
                    reqs_before = req_count;
                    apb_transfer(1'b0, t.addr, t.wdata, t.strb, rdata, err);
                    check_err("o_pslverr", err, t.exp_err);
                    if (!t.exp_err) begin
                        check_word("o_prdata", rdata, t.exp_data);
                    end
                    if (t.op == "H" && req_count != reqs_before) begin
                        $display("read of %h should have hit but went to memory", t.addr);
                        other_errors++;
                    end
                    if (t.op == "M" && req_count == reqs_before) begin
                        $display("read of %h should have missed but made no request", t.addr);
                        other_errors++;
                    end
                end
                "W": begin
                    apb_transfer(1'b1, t.addr, t.wdata, t.strb, rdata, err);
                    check_err("o_pslverr", err, t.exp_err);
                end
                "L": begin
                    if (wb_count == wb_seen) begin
                        $display("no write-back seen for the line of %h", t.addr);
                        other_errors++;
                    end else begin
                        exp_line = pattern_line({t.addr[31:4], 4'h0});
                        exp_line[t.addr[3:2]] = t.exp_data;   // the one dirty word
                        check_word("o_mem_addr", wb_addr, {t.addr[31:4], 4'h0});
                        check_line("o_mem_wdata", wb_line, exp_line);
                    end
                    wb_seen = wb_count;
                end
                default: begin
                    $display("unknown operation in trace line %0d", i + 1);
                    other_errors++;
                end
            endcase
        end

        repeat (4) @(posedge clk);
        $display("%0d operations, errors: word %0d line %0d flag %0d other %0d",
                 ops.size(), word_errors, line_errors, flag_errors, other_errors);
        if (word_errors + line_errors + flag_errors + other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/cache_geom_pkg.sv
rtl/bus_pkg.sv
rtl/dcache_ifs.sv
rtl/way_ram.sv
rtl/cache_arrays.sv
rtl/apb_cache_ctrl.sv
rtl/line_mem_port.sv
rtl/dcache_top.sv
testbench/tb_line_memory.sv
testbench/tb_dcache.sv

//--- testbench/dcache_trace.txt
# columns: op addr wdata strb expected_rdata expected_err, all hex
# op: R read, H read that must hit, M read that must miss, W write, L check last write-back
M 00000040 00000000 f C0DEA540 0
H 00000040 00000000 f C0DEA540 0
H 00000046 00000000 3 0000C0DE 0
H 00000045 00000000 1 000000A5 0
W 00000049 0000003C 1 00000000 0
W 0000004A 0000BEEF 3 00000000 0
H 00000048 00000000 f BEEF3C48 0
H 00000049 00000000 1 0000003C 0
W 00000084 00000077 1 00000000 0
H 00000084 00000000 f C0DEA577 0
H 00000088 00000000 f C0DEA588 0
M 00000140 00000000 f C0DEA440 0
M 00000240 00000000 f C0DEA740 0
L 00000048 00000000 0 BEEF3C48 0
M 00000048 00000000 f BEEF3C48 0
M 000000C0 00000000 f C0DEA5C0 0
M 000001C0 00000000 f C0DEA4C0 0
H 000000C4 00000000 f C0DEA5C4 0
M 000002C0 00000000 f C0DEA7C0 0
H 000000C8 00000000 f C0DEA5C8 0
M 000001CC 00000000 f C0DEA4CC 0
W 00000081 00001234 3 00000000 1
R 00000082 00000000 f 00000000 1
W 00000086 DEADBEEF f 00000000 1
H 00000084 00000000 f C0DEA577 0
H 00000083 00000000 1 000000C0 0
